/* logic/pic_pkg.sv */
package pic_pkg;

	localparam int NUM_IRQ = 8;
	localparam int LEVEL_W = 3;
	localparam int BASE_W  = 5;

	// OCW2 command field.
	localparam logic [2:0] EOI_NONSPEC = 3'b001;
	localparam logic [2:0] EOI_SPEC    = 3'b011;

	// Byte written by the host, read according to address and sequence state.
	typedef union packed {
		struct packed {
			logic [2:0] addr_hi;  // 8080 only, ignored.
			logic       marker;
			logic       ltim;
			logic       adi;
			logic       sngl;
			logic       ic4;
		} icw1;
		struct packed {
			logic [BASE_W-1:0]  base;
			logic [7-BASE_W:0]  addr_lo;
		} icw2;
		struct packed {
			logic [5:0] rsvd;
			logic       aeoi;
			logic       upm;
		} icw4;
		struct packed {
			logic [2:0]         eoi_cmd;
			logic [1:0]         rsvd;
			logic [LEVEL_W-1:0] level;
		} ocw2;
		struct packed {
			logic [3:0] rsvd;
			logic       marker;
			logic       poll;
			logic       rr;
			logic       ris;
		} ocw3;
	} cmd_word_u;

	typedef enum logic [1:0] {
		INIT_READY,
		INIT_WAIT_ICW2,
		INIT_WAIT_ICW4
	} init_state_e;

	typedef enum logic [2:0] {
		ACK_IDLE,
		ACK_FIRST_LOW,
		ACK_BETWEEN,
		ACK_SECOND_LOW,
		ACK_POLL_WAIT
	} ack_state_e;

endpackage

/* logic/pic_ifs.sv */
`timescale 1ns/10ps

interface pic_write_if import pic_pkg::*; ();

	logic      icw1_wr;
	logic      icw2_wr;
	logic      icw4_wr;
	logic      ocw1_wr;
	logic      ocw2_wr;
	logic      ocw3_wr;
	cmd_word_u word;  // Valid with any strobe.

	modport sequencer (
		output icw1_wr, icw2_wr, icw4_wr, ocw1_wr, ocw2_wr, ocw3_wr, word
	);

	modport receiver (
		input icw1_wr, icw2_wr, icw4_wr, ocw1_wr, ocw2_wr, ocw3_wr, word
	);

endinterface

interface pic_config_if import pic_pkg::*; ();

	logic [BASE_W-1:0]  vector_base;
	logic               level_mode;
	logic               auto_eoi;
	logic [NUM_IRQ-1:0] mask;
	logic               read_isr;

	modport source (output vector_base, level_mode, auto_eoi, mask, read_isr);
	modport receiver (input vector_base, level_mode, auto_eoi, mask, read_isr);

endinterface

/* logic/init_sequencer.sv */
`timescale 1ns/10ps

module init_sequencer import pic_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           wr,
	input  logic           a0,
	input  logic [7:0]     din,
	pic_write_if.sequencer wr_bus
);

	init_state_e state;
	init_state_e state_next;
	cmd_word_u   cmd;
	logic        ic4_q;    // ICW4 will follow ICW2.
	logic        cmd_wr;
	logic        data_wr;

	assign cmd     = din;
	assign cmd_wr  = wr & ~a0;
	assign data_wr = wr & a0;

	assign wr_bus.word    = cmd;
	assign wr_bus.icw1_wr = cmd_wr & cmd.icw1.marker;  // Restarts from any state.
	assign wr_bus.icw2_wr = data_wr & (state == INIT_WAIT_ICW2);
	assign wr_bus.icw4_wr = data_wr & (state == INIT_WAIT_ICW4);
	assign wr_bus.ocw1_wr = data_wr & (state == INIT_READY);
	assign wr_bus.ocw2_wr = cmd_wr & ~cmd.icw1.marker & ~cmd.ocw3.marker & (state == INIT_READY);
	assign wr_bus.ocw3_wr = cmd_wr & ~cmd.icw1.marker & cmd.ocw3.marker & (state == INIT_READY);

	always_comb
	begin
		state_next = state;
		if (wr_bus.icw1_wr)
			state_next = INIT_WAIT_ICW2;
		else if (wr_bus.icw2_wr)
			state_next = ic4_q ? INIT_WAIT_ICW4 : INIT_READY;
		else if (wr_bus.icw4_wr)
			state_next = INIT_READY;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= INIT_READY;
			ic4_q <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (wr_bus.icw1_wr)
				ic4_q <= cmd.icw1.ic4;
		end
	end

endmodule

/* logic/config_regs.sv */
`timescale 1ns/10ps

module config_regs (
	input  logic          clk,
	input  logic          rst_n,
	pic_write_if.receiver wr_bus,
	pic_config_if.source  cfg
);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg.vector_base <= '0;
			cfg.level_mode  <= 1'b0;  // Edge triggered.
			cfg.auto_eoi    <= 1'b0;
			cfg.mask        <= '0;
			cfg.read_isr    <= 1'b0;
		end
		else
		begin
			if (wr_bus.icw1_wr)
			begin
				cfg.level_mode <= wr_bus.word.icw1.ltim;
				cfg.auto_eoi   <= 1'b0;
				cfg.mask       <= '0;
				cfg.read_isr   <= 1'b0;  // Back to IRR reads.
			end
			if (wr_bus.icw2_wr)
				cfg.vector_base <= wr_bus.word.icw2.base;
			if (wr_bus.icw4_wr)
				cfg.auto_eoi <= wr_bus.word.icw4.aeoi;
			if (wr_bus.ocw1_wr)
				cfg.mask <= wr_bus.word;
			if (wr_bus.ocw3_wr && wr_bus.word.ocw3.rr)
				cfg.read_isr <= wr_bus.word.ocw3.ris;
		end
	end

endmodule

/* logic/irq_request.sv */
`timescale 1ns/10ps

module irq_request import pic_pkg::*; #(
	parameter int NUM_IRQ = pic_pkg::NUM_IRQ
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NUM_IRQ-1:0]  irq,
	pic_write_if.receiver       wr_bus,
	pic_config_if.receiver      cfg,
	input  logic                ack_set,
	input  logic [LEVEL_W-1:0]  ack_level,
	output logic [NUM_IRQ-1:0]  irr
);

	logic [NUM_IRQ-1:0] irq_prev;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			irq_prev <= '0;
			irr      <= '0;
		end
		else
		begin
			irq_prev <= irq;
			if (wr_bus.icw1_wr)
				irr <= '0;
			else
			begin
				for (int i = 0; i < NUM_IRQ; i++)
				begin
					if (ack_set && ack_level == LEVEL_W'(i))
						irr[i] <= 1'b0;  // Taken into service.
					else if (cfg.level_mode)
						irr[i] <= irq[i];
					else if (irq[i] && !irq_prev[i])
						irr[i] <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/priority_resolver.sv */
`timescale 1ns/10ps

module priority_resolver import pic_pkg::*; #(
	parameter int NUM_IRQ = pic_pkg::NUM_IRQ
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NUM_IRQ-1:0]  irr,
	input  logic [NUM_IRQ-1:0]  isr,
	pic_config_if.receiver      cfg,
	output logic                req_valid,
	output logic [LEVEL_W-1:0]  req_level,
	output logic                int_out
);

	logic [NUM_IRQ-1:0] pending;
	logic               found;
	logic               blocked;  // Equal or higher level in service.

	assign pending = irr & ~cfg.mask[NUM_IRQ-1:0];

	// IR0 wins.
	always_comb
	begin
		found     = 1'b0;
		blocked   = 1'b0;
		req_level = '0;
		for (int i = 0; i < NUM_IRQ; i++)
		begin
			if (!found && isr[i])
				blocked = 1'b1;
			if (!found && pending[i])
			begin
				found     = 1'b1;
				req_level = LEVEL_W'(i);
			end
		end
		req_valid = found & ~blocked;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			int_out <= 1'b0;
		else
			int_out <= req_valid;
	end

endmodule

/* logic/in_service.sv */
`timescale 1ns/10ps

module in_service import pic_pkg::*; #(
	parameter int NUM_IRQ = pic_pkg::NUM_IRQ
) (
	input  logic                clk,
	input  logic                rst_n,
	pic_write_if.receiver       wr_bus,
	input  logic                ack_set,
	input  logic [LEVEL_W-1:0]  ack_level,
	input  logic                aeoi_clear,
	output logic [NUM_IRQ-1:0]  isr
);

	logic [NUM_IRQ-1:0] top_bit;  // Lowest set bit, one hot.
	logic [NUM_IRQ-1:0] set_vec;
	logic [NUM_IRQ-1:0] clr_vec;

	assign top_bit = isr & (~isr + 1'b1);

	always_comb
	begin
		set_vec = '0;
		clr_vec = '0;
		if (aeoi_clear)
			clr_vec = top_bit;
		if (wr_bus.ocw2_wr && wr_bus.word.ocw2.eoi_cmd == EOI_NONSPEC)
			clr_vec = clr_vec | top_bit;
		for (int i = 0; i < NUM_IRQ; i++)
		begin
			if (ack_set && ack_level == LEVEL_W'(i))
				set_vec[i] = 1'b1;
			if (wr_bus.ocw2_wr && wr_bus.word.ocw2.eoi_cmd == EOI_SPEC &&
				wr_bus.word.ocw2.level == LEVEL_W'(i))
				clr_vec[i] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			isr <= '0;
		else if (wr_bus.icw1_wr)
			isr <= '0;
		else
			isr <= (isr & ~clr_vec) | set_vec;
	end

endmodule

/* logic/ack_sequencer.sv */
`timescale 1ns/10ps

module ack_sequencer import pic_pkg::*; #(
	parameter int NUM_IRQ = pic_pkg::NUM_IRQ
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                inta_n,
	input  logic                rd,
	input  logic                a0,
	pic_write_if.receiver       wr_bus,
	pic_config_if.receiver      cfg,
	input  logic [NUM_IRQ-1:0]  irr,
	input  logic [NUM_IRQ-1:0]  isr,
	input  logic                req_valid,
	input  logic [LEVEL_W-1:0]  req_level,
	output logic                ack_set,
	output logic [LEVEL_W-1:0]  ack_level,
	output logic                aeoi_clear,
	output logic [7:0]          dout,
	output logic                dout_en
);

	ack_state_e         state;
	ack_state_e         state_next;
	logic               inta_prev;
	logic               rd_prev;
	logic               inta_fall;
	logic               inta_rise;
	logic               rd_rise;
	logic               rd_fall;
	logic               capture;
	logic               arm_poll;
	logic               valid_q;   // A request was taken at capture.
	logic [LEVEL_W-1:0] level_q;
	logic               poll_hit;
	logic [LEVEL_W-1:0] poll_level;
	logic               vec_out;

	assign inta_fall = inta_prev & ~inta_n;
	assign inta_rise = ~inta_prev & inta_n;
	assign rd_rise   = ~rd_prev & rd;
	assign rd_fall   = rd_prev & ~rd;

	assign capture  = (state == ACK_IDLE && inta_fall) || (state == ACK_POLL_WAIT && rd_rise);
	assign arm_poll = state == ACK_IDLE && !inta_fall && wr_bus.ocw3_wr && wr_bus.word.ocw3.poll;

	assign ack_set = (state == ACK_IDLE && inta_fall && req_valid) ||
		(state == ACK_POLL_WAIT && rd_fall && valid_q);
	assign ack_level  = (state == ACK_POLL_WAIT) ? level_q : req_level;
	assign aeoi_clear = state == ACK_SECOND_LOW && inta_rise && cfg.auto_eoi && valid_q;

	// Live request in the cycle rd rises, held value after.
	assign poll_hit   = rd_rise ? req_valid : valid_q;
	assign poll_level = rd_rise ? req_level : level_q;
	assign vec_out    = ~inta_n && (state == ACK_BETWEEN || state == ACK_SECOND_LOW);

	always_comb
	begin
		state_next = state;
		case (state)
			ACK_IDLE:
				if (inta_fall)
					state_next = ACK_FIRST_LOW;
				else if (arm_poll)
					state_next = ACK_POLL_WAIT;
			ACK_FIRST_LOW:
				if (inta_rise)
					state_next = ACK_BETWEEN;
			ACK_BETWEEN:
				if (inta_fall)
					state_next = ACK_SECOND_LOW;
			ACK_SECOND_LOW:
				if (inta_rise)
					state_next = ACK_IDLE;
			ACK_POLL_WAIT:
				if (rd_fall)
					state_next = ACK_IDLE;
			default:
				state_next = ACK_IDLE;
		endcase
	end

	always_comb
	begin
		dout_en = 1'b0;
		dout    = '0;
		if (vec_out)
		begin
			dout_en = 1'b1;
			dout    = {cfg.vector_base, level_q};
		end
		else if (rd && state == ACK_POLL_WAIT)
		begin
			dout_en = 1'b1;
			if (poll_hit)
				dout = {1'b1, 4'b0000, poll_level};
		end
		else if (rd)
		begin
			dout_en = 1'b1;
			if (a0)
				dout = cfg.mask;
			else if (cfg.read_isr)
				dout = 8'(isr);
			else
				dout = 8'(irr);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= ACK_IDLE;
			inta_prev <= 1'b1;
			rd_prev   <= 1'b0;
			valid_q   <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			inta_prev <= inta_n;
			rd_prev   <= rd;
			if (capture)
				valid_q <= req_valid;
			else if (arm_poll)
				valid_q <= 1'b0;  // Nothing taken until rd rises.
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			level_q <= req_level;
	end

endmodule

/* logic/pic_top.sv */
`timescale 1ns/10ps

module pic_top import pic_pkg::*; #(
	parameter int NUM_IRQ = pic_pkg::NUM_IRQ
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  logic               a0,
	input  logic [7:0]         din,
	input  logic               rd,
	output logic [7:0]         dout,
	output logic               dout_en,
	input  logic [NUM_IRQ-1:0] irq,
	input  logic               inta_n,
	output logic               int_out
);

	logic [NUM_IRQ-1:0] irr;
	logic [NUM_IRQ-1:0] isr;
	logic               req_valid;
	logic [LEVEL_W-1:0] req_level;
	logic               ack_set;
	logic [LEVEL_W-1:0] ack_level;
	logic               aeoi_clear;

	pic_write_if  wr_bus ();
	pic_config_if cfg ();

	init_sequencer u_init_sequencer (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (wr),
		.a0     (a0),
		.din    (din),
		.wr_bus (wr_bus.sequencer)
	);

	config_regs u_config_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr_bus (wr_bus.receiver),
		.cfg    (cfg.source)
	);

	irq_request #(.NUM_IRQ(NUM_IRQ)) u_irq_request (
		.clk       (clk),
		.rst_n     (rst_n),
		.irq       (irq),
		.wr_bus    (wr_bus.receiver),
		.cfg       (cfg.receiver),
		.ack_set   (ack_set),
		.ack_level (ack_level),
		.irr       (irr)
	);

	priority_resolver #(.NUM_IRQ(NUM_IRQ)) u_priority_resolver (
		.clk       (clk),
		.rst_n     (rst_n),
		.irr       (irr),
		.isr       (isr),
		.cfg       (cfg.receiver),
		.req_valid (req_valid),
		.req_level (req_level),
		.int_out   (int_out)
	);

	in_service #(.NUM_IRQ(NUM_IRQ)) u_in_service (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_bus     (wr_bus.receiver),
		.ack_set    (ack_set),
		.ack_level  (ack_level),
		.aeoi_clear (aeoi_clear),
		.isr        (isr)
	);

	ack_sequencer #(.NUM_IRQ(NUM_IRQ)) u_ack_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.inta_n     (inta_n),
		.rd         (rd),
		.a0         (a0),
		.wr_bus     (wr_bus.receiver),
		.cfg        (cfg.receiver),
		.irr        (irr),
		.isr        (isr),
		.req_valid  (req_valid),
		.req_level  (req_level),
		.ack_set    (ack_set),
		.ack_level  (ack_level),
		.aeoi_clear (aeoi_clear),
		.dout       (dout),
		.dout_en    (dout_en)
	);

endmodule

/* bench/pic_checker.sv */
`timescale 1ns/10ps

module pic_checker (
	input logic clk,
	input logic rst_n,
	input logic rd,
	input logic inta_n,
	input logic dout_en,
	input logic ack_set,
	input logic req_valid,
	input logic icw1_wr,
	input logic int_out
);

	logic rd_q;
	logic poll_ok;  // Request state as the last read began.

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_q    <= 1'b0;
			poll_ok <= 1'b0;
		end
		else
		begin
			rd_q <= rd;
			if (rd && !rd_q)
				poll_ok <= req_valid;
		end
	end

	// Bus only driven for a read or an INTA pulse.
	bus_needs_access: assert property (@(posedge clk) disable iff (!rst_n)
		dout_en |-> (rd || !inta_n))
		else $error("dout_en high without rd or a low inta_n");

	// INTA takes the live request, a poll the one seen when rd rose.
	ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		ack_set |-> (inta_n ? poll_ok : req_valid))
		else $error("ack_set without a valid request at capture");

	icw1_drops_int: assert property (@(posedge clk) disable iff (!rst_n)
		$past(icw1_wr, 2) |-> !int_out)
		else $error("int_out high after an ICW1 write");

endmodule

bind pic_top pic_checker u_pic_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.rd        (rd),
	.inta_n    (inta_n),
	.dout_en   (dout_en),
	.ack_set   (ack_set),
	.req_valid (req_valid),
	.icw1_wr   (wr_bus.icw1_wr),
	.int_out   (int_out)
);

/* bench/pic_tb.sv */
`timescale 1ns/10ps

module pic_tb;

	localparam int N_IRQ      = 8;
	localparam int ITERATIONS = 400;
	localparam int PERIOD_NS  = 8;
	localparam int TIMEOUT_NS = ITERATIONS * 60 * PERIOD_NS;

	logic             clk;
	logic             rst_n;
	logic             wr;
	logic             a0;
	logic [7:0]       din;
	logic             rd;
	logic [7:0]       dout;
	logic             dout_en;
	logic [N_IRQ-1:0] irq;
	logic             inta_n;
	logic             int_out;

	logic [7:0] m_irr;  // Reference model.
	logic [7:0] m_isr;
	logic [7:0] m_mask;
	logic [4:0] m_base;
	logic       m_aeoi;
	int         checks;
	int         errors;

	pic_top #(.NUM_IRQ(N_IRQ)) DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (wr),
		.a0      (a0),
		.din     (din),
		.rd      (rd),
		.dout    (dout),
		.dout_en (dout_en),
		.irq     (irq),
		.inta_n  (inta_n),
		.int_out (int_out)
	);

	always #(PERIOD_NS / 2) clk = ~clk;

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error: %s at %0t ns", what, $time);
	endtask

	// Tasks below start and end 1 ns after a rising edge.
	task automatic host_write(input logic addr, input logic [7:0] data);
		wr  = 1'b1;
		a0  = addr;
		din = data;
		@(posedge clk);
		#1;
		wr = 1'b0;
	endtask

	task automatic read_bus(input logic addr, output logic [7:0] data);
		rd = 1'b1;
		a0 = addr;
		@(negedge clk);
		data = dout;
		checks++;
		if (!dout_en)
			report_failure("dout_en stayed low during a host read");
		@(posedge clk);
		#1;
		rd = 1'b0;
	endtask

	task automatic inta_cycle(output logic [7:0] vector);
		inta_n = 1'b0;
		@(posedge clk);
		#1;
		inta_n = 1'b1;
		@(posedge clk);
		#1;
		inta_n = 1'b0;  // Second pulse carries the vector.
		@(negedge clk);
		vector = dout;
		checks++;
		if (!dout_en)
			report_failure("dout_en low during the second INTA pulse");
		@(posedge clk);
		#1;
		inta_n = 1'b1;
	endtask

	task automatic pulse_irq(input logic [7:0] bits);
		irq = bits;
		@(posedge clk);
		#1;
		irq   = '0;
		m_irr = m_irr | bits;
	endtask

	task automatic wait_int(output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < 20)
		begin
			@(negedge clk);
			seen = int_out;
			n++;
		end
		@(posedge clk);
		#1;
	endtask

	// OCW3 picks the register, then a read at a0 = 0.
	task automatic check_status(input logic want_isr);
		logic [7:0] val;
		host_write(1'b0, want_isr ? 8'h0B : 8'h0A);
		read_bus(1'b0, val);
		if (want_isr)
			compare("isr", val, m_isr);
		else
			compare("irr", val, m_irr);
	endtask

	task automatic init_edge_mode();
		logic ic4;
		ic4    = 1'($urandom);
		m_base = 5'($urandom);
		m_aeoi = ic4 & 1'($urandom);
		host_write(1'b0, {7'b0001000, ic4});
		host_write(1'b1, {m_base, 3'b000});
		if (ic4)
			host_write(1'b1, {6'b000000, m_aeoi, 1'b1});
		m_irr  = '0;
		m_isr  = '0;
		m_mask = '0;
	endtask

	function automatic logic lowest_set(input logic [7:0] v, output logic [2:0] lvl);
		logic any;
		any = 1'b0;
		lvl = '0;
		for (int i = N_IRQ - 1; i >= 0; i--)
		begin
			if (v[i])
			begin
				any = 1'b1;
				lvl = 3'(i);
			end
		end
		return any;
	endfunction

	// Highest unmasked request, valid only above everything in service.
	function automatic logic model_request(output logic [2:0] lvl);
		logic [8:0] upto;
		logic       any;
		any  = lowest_set(m_irr & ~m_mask, lvl);
		upto = (9'd2 << lvl) - 9'd1;
		return any && ((m_isr & upto[7:0]) == 8'h00);
	endfunction

	initial
	begin
		logic [7:0] val;
		logic [7:0] expected;
		logic [2:0] lvl;
		logic [2:0] eoi_lvl;
		logic       seen;
		logic       req;
		int         served;
		int         seed;

		clk    = 1'b0;
		rst_n  = 1'b0;
		wr     = 1'b0;
		a0     = 1'b0;
		din    = '0;
		rd     = 1'b0;
		irq    = '0;
		inta_n = 1'b1;
		checks = 0;
		errors = 0;
		m_irr  = '0;
		m_isr  = '0;
		m_mask = '0;
		m_base = '0;
		m_aeoi = 1'b0;
		seed   = $urandom(97);
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int it = 0; it < ITERATIONS; it++)
		begin
			init_edge_mode();
			m_mask = 8'($urandom) & 8'($urandom);
			host_write(1'b1, m_mask);
			read_bus(1'b1, val);
			compare("mask", val, m_mask);

			pulse_irq(8'($urandom) & 8'($urandom) & 8'($urandom));
			check_status(1'b0);

			served = 0;
			req    = model_request(lvl);
			while (req && served < N_IRQ)
			begin
				wait_int(seen);
				checks++;
				if (!seen)
				begin
					report_failure("int_out never rose for a pending request");
					break;
				end
				inta_cycle(val);
				compare("vector", val, {m_base, lvl});
				m_irr[lvl] = 1'b0;
				if (!m_aeoi)
					m_isr[lvl] = 1'b1;  // AEOI drops it at the second INTA.
				check_status(1'b1);
				if (!m_aeoi)
				begin
					if ($urandom % 2 == 1)
					begin
						host_write(1'b0, 8'h20);  // Non-specific EOI.
						if (lowest_set(m_isr, eoi_lvl))
							m_isr[eoi_lvl] = 1'b0;
					end
					else
					begin
						eoi_lvl = ($urandom % 4 == 0) ? 3'($urandom) : lvl;
						host_write(1'b0, {3'b011, 2'b00, eoi_lvl});
						m_isr[eoi_lvl] = 1'b0;
					end
					check_status(1'b1);
				end
				served++;
				req = model_request(lvl);
			end

			// Masked or blocked lines only.
			if (!model_request(lvl))
			begin
				repeat (2) @(negedge clk);
				checks++;
				if (int_out)
					report_failure("int_out high with no serviceable request pending");
				@(posedge clk);
				#1;
			end

			pulse_irq(8'($urandom) & 8'($urandom) & 8'($urandom));
			if (model_request(lvl))
			begin
				expected   = {5'b10000, lvl};
				m_irr[lvl] = 1'b0;
				m_isr[lvl] = 1'b1;
			end
			else
				expected = 8'h00;
			host_write(1'b0, 8'h0C);  // OCW3 with poll.
			read_bus(1'b0, val);
			compare("poll", val, expected);
			check_status(1'b1);
			check_status(1'b0);

			host_write(1'b0, 8'h18);  // ICW1, level triggered.
			host_write(1'b1, {m_base, 3'b000});
			m_irr  = '0;
			m_isr  = '0;
			m_mask = '0;
			m_aeoi = 1'b0;
			lvl    = 3'($urandom);
			irq    = 8'd1 << lvl;
			@(posedge clk);
			#1;
			m_irr = irq;
			check_status(1'b0);
			wait_int(seen);
			checks++;
			if (!seen)
				report_failure("int_out never rose for a level request");
			irq   = '0;  // Withdrawn before any INTA.
			m_irr = '0;
			repeat (3) @(negedge clk);
			checks++;
			if (int_out)
				report_failure("int_out stayed high after the level request fell");
			@(posedge clk);
			#1;
			check_status(1'b0);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* files.f */
logic/pic_pkg.sv
logic/pic_ifs.sv
logic/init_sequencer.sv
logic/config_regs.sv
logic/irq_request.sv
logic/priority_resolver.sv
logic/in_service.sv
logic/ack_sequencer.sv
logic/pic_top.sv
bench/pic_checker.sv
bench/pic_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PIC testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module pic_tb -o pic_sim

./obj_dir/pic_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
